/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire rv32i_pkg::alu_ops         aluop,
	input  wire rv32i_pkg::branch_funct3_t cmpop,
	input  wire rv32i_pkg::rv32i_word      a,
	input  wire rv32i_pkg::rv32i_word      b,
	input  wire rv32i_pkg::rv32i_word      cmp_a,
	input  wire rv32i_pkg::rv32i_word      cmp_b,
	output rv32i_pkg::rv32i_word           f,
	output logic                           br_en
);

	always_comb begin
		case (aluop)
			rv32i_pkg::alu_add: f = a + b;
			rv32i_pkg::alu_sll: f = a << b[4:0];
			rv32i_pkg::alu_sra: f = rv32i_pkg::rv32i_word'($signed(a) >>> b[4:0]);
			rv32i_pkg::alu_sub: f = a - b;
			rv32i_pkg::alu_xor: f = a ^ b;
			rv32i_pkg::alu_srl: f = a >> b[4:0];
			rv32i_pkg::alu_or:  f = a | b;
			rv32i_pkg::alu_and: f = a & b;
			default:            f = a + b;
		endcase
	end

	// branch compare, also slt/sltu
	always_comb begin
		case (cmpop)
			rv32i_pkg::beq:  br_en = (cmp_a == cmp_b);
			rv32i_pkg::bne:  br_en = (cmp_a != cmp_b);
			rv32i_pkg::blt:  br_en = ($signed(cmp_a) < $signed(cmp_b));
			rv32i_pkg::bge:  br_en = ($signed(cmp_a) >= $signed(cmp_b));
			rv32i_pkg::bltu: br_en = (cmp_a < cmp_b);
			rv32i_pkg::bgeu: br_en = (cmp_a >= cmp_b);
			default:         br_en = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* control.sv */
`timescale 1ns/1ps
`default_nettype none

module control (
	input  wire rv32i_pkg::rv32i_word data,
	input  wire                       flush,
	output rv32i_pkg::control_word_t  cw
);

	logic [2:0] funct3;
	logic       funct7_5;

	assign funct3   = data[14:12];
	assign funct7_5 = data[30];

	always_comb begin
		cw                = '0;
		cw.opcode         = rv32i_pkg::rv32i_opcode'(data[6:0]);
		cw.aluop          = rv32i_pkg::alu_add;
		cw.cmpop          = rv32i_pkg::branch_funct3_t'(funct3);
		cw.alumux1_sel    = rv32i_pkg::mux1_rs1;
		cw.alumux2_sel    = rv32i_pkg::mux2_i_imm;
		cw.cmpmux_sel     = rv32i_pkg::cmp_rs2;
		cw.regfilemux_sel = rv32i_pkg::rf_alu_out;
		cw.src1           = data[19:15];
		cw.src2           = data[24:20];
		cw.dest           = data[11:7];
		cw.i_imm          = {{21{data[31]}}, data[30:20]};
		cw.s_imm          = {{21{data[31]}}, data[30:25], data[11:7]};
		cw.b_imm          = {{20{data[31]}}, data[7], data[30:25], data[11:8], 1'b0};
		cw.u_imm          = {data[31:12], 12'h000};
		cw.j_imm          = {{12{data[31]}}, data[19:12], data[20], data[30:21], 1'b0};

		case (data[6:0])
			rv32i_pkg::op_lui: begin
				cw.load_regfile   = 1'b1;
				cw.regfilemux_sel = rv32i_pkg::rf_u_imm;
			end
			rv32i_pkg::op_auipc: begin
				cw.load_regfile = 1'b1;
				cw.alumux1_sel  = rv32i_pkg::mux1_pc;
				cw.alumux2_sel  = rv32i_pkg::mux2_u_imm;
			end
			rv32i_pkg::op_jal: begin
				cw.load_regfile   = 1'b1;
				cw.alumux1_sel    = rv32i_pkg::mux1_pc;
				cw.alumux2_sel    = rv32i_pkg::mux2_j_imm;
				cw.regfilemux_sel = rv32i_pkg::rf_pc_plus4;
			end
			rv32i_pkg::op_jalr: begin
				cw.load_regfile   = 1'b1;
				cw.rs1_valid      = 1'b1;
				cw.regfilemux_sel = rv32i_pkg::rf_pc_plus4;
			end
			rv32i_pkg::op_br: begin
				cw.rs1_valid   = 1'b1;
				cw.rs2_valid   = 1'b1;
				cw.alumux1_sel = rv32i_pkg::mux1_pc;
				cw.alumux2_sel = rv32i_pkg::mux2_b_imm;
			end
			rv32i_pkg::op_imm, rv32i_pkg::op_reg: begin
				cw.load_regfile = 1'b1;
				cw.rs1_valid    = 1'b1;
				cw.aluop        = rv32i_pkg::alu_ops'(funct3);
				if (funct3 == 3'b101 && funct7_5)
					cw.aluop = rv32i_pkg::alu_sra;
				// bit 5 of the opcode separates reg from imm form
				if (data[5]) begin
					cw.rs2_valid   = 1'b1;
					cw.alumux2_sel = rv32i_pkg::mux2_rs2;
					if (funct3 == 3'b000 && funct7_5)
						cw.aluop = rv32i_pkg::alu_sub;
				end else begin
					cw.cmpmux_sel = rv32i_pkg::cmp_i_imm;
				end
				// slt and sltu come from the comparator
				if (funct3 == 3'b010 || funct3 == 3'b011) begin
					cw.cmpop          = funct3[0] ? rv32i_pkg::bltu : rv32i_pkg::blt;
					cw.regfilemux_sel = rv32i_pkg::rf_br_en;
				end
			end
			default: begin
				cw.load_regfile = 1'b0;
			end
		endcase

		cw.rd_valid = cw.load_regfile && (cw.dest != 5'd0);

		if (flush) begin
			cw.load_regfile = 1'b0;
			cw.rd_valid     = 1'b0;
			cw.flush        = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu (
	input  wire                       clk,
	input  wire                       rst,
	input  wire rv32i_pkg::rv32i_word inst,
	input  wire                       load_pipeline,
	output rv32i_pkg::rv32i_word      inst_addr,
	output logic                      wb_valid,
	output rv32i_pkg::rv32i_reg       wb_dest,
	output rv32i_pkg::rv32i_word      wb_data
);

	rv32i_pkg::rv32i_word ifid_pc;
	rv32i_pkg::rv32i_word ifid_inst;
	logic                 ifid_flush;
	logic                 redirect;
	rv32i_pkg::rv32i_word redirect_target;

	fetch_unit u_fetch (
		.clk             (clk),
		.rst             (rst),
		.load_pipeline   (load_pipeline),
		.inst            (inst),
		.redirect        (redirect),
		.redirect_target (redirect_target),
		.inst_addr       (inst_addr),
		.ifid_pc         (ifid_pc),
		.ifid_inst       (ifid_inst),
		.ifid_flush      (ifid_flush)
	);

	datapath u_datapath (
		.clk             (clk),
		.rst             (rst),
		.load_pipeline   (load_pipeline),
		.ifid_pc         (ifid_pc),
		.ifid_inst       (ifid_inst),
		.ifid_flush      (ifid_flush),
		.redirect        (redirect),
		.redirect_target (redirect_target),
		.wb_valid        (wb_valid),
		.wb_dest         (wb_dest),
		.wb_data         (wb_data)
	);

endmodule

`default_nettype wire

/* cpu_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_sva (
	input wire                       clk,
	input wire                       rst,
	input wire                       load_pipeline,
	input wire rv32i_pkg::rv32i_word inst_addr,
	input wire                       wb_valid
);

	// fetch only steps by words
	a_inst_align: assert property (@(posedge clk) disable iff (rst)
		inst_addr[1:0] == 2'b00)
		else $error("inst_addr 0x%08h is not word aligned", inst_addr);

	a_wb_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(wb_valid))
		else $error("wb_valid is unknown");

	// frozen pipeline holds the pc
	a_addr_hold: assert property (@(posedge clk) disable iff (rst)
		!load_pipeline |=> $stable(inst_addr))
		else $error("inst_addr moved while load_pipeline was low");

	a_reset_quiet: assert property (@(posedge clk)
		rst |=> !wb_valid)
		else $error("wb_valid high in the cycle after reset");

endmodule

`default_nettype wire

/* cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

	localparam int NUM_ROWS       = 21;
	localparam int HALF_ROWS      = NUM_ROWS / 2;
	localparam int RESET_CYCLES   = 10;
	localparam int TAIL_CYCLES    = 10;
	localparam int TIMEOUT_CYCLES = 20 * NUM_ROWS + 50;
	localparam int ROM_WORDS      = 64;

	typedef struct packed {
		rv32i_pkg::rv32i_reg  dest;
		rv32i_pkg::rv32i_word data;
	} commit_t;

	logic                 clk;
	logic                 rst;
	rv32i_pkg::rv32i_word inst;
	logic                 load_pipeline;
	rv32i_pkg::rv32i_word inst_addr;
	logic                 wb_valid;
	rv32i_pkg::rv32i_reg  wb_dest;
	rv32i_pkg::rv32i_word wb_data;
	rv32i_pkg::rv32i_word rom [ROM_WORDS];
	int                   rows_done = 0;
	int                   cycle_count = 0;

	// commits in program order, worked out by hand from the program below
	commit_t expected [NUM_ROWS] = '{
		'{5'd1,  32'h0000_0005},
		'{5'd2,  32'h0000_000c},
		'{5'd3,  32'h0000_0011},
		'{5'd4,  32'h0000_000c},
		'{5'd5,  32'h1234_5000},
		'{5'd6,  32'h0000_1014},
		'{5'd7,  32'hedcb_afff},
		'{5'd8,  32'h0000_00c0},
		'{5'd9,  32'hffed_cbaf},
		'{5'd10, 32'h0000_000e},
		'{5'd11, 32'h0000_0001},
		'{5'd12, 32'h0000_0000},
		'{5'd13, 32'h0000_00ce},
		'{5'd14, 32'h1224_4000},
		'{5'd17, 32'h0000_0021},
		'{5'd18, 32'h0000_0001},
		'{5'd19, 32'h0000_0054},
		'{5'd22, 32'h0000_0079},
		'{5'd23, 32'h0000_0064},
		'{5'd26, 32'h0000_00b8},
		'{5'd30, 32'hffff_b72e}
	};

	cpu u_cpu (
		.clk           (clk),
		.rst           (rst),
		.inst          (inst),
		.load_pipeline (load_pipeline),
		.inst_addr     (inst_addr),
		.wb_valid      (wb_valid),
		.wb_dest       (wb_dest),
		.wb_data       (wb_data)
	);

	bind cpu cpu_sva u_sva (
		.clk           (clk),
		.rst           (rst),
		.load_pipeline (load_pipeline),
		.inst_addr     (inst_addr),
		.wb_valid      (wb_valid)
	);

	function automatic rv32i_pkg::rv32i_word r_insn(input logic [4:0] rd, input logic [2:0] f3,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic [6:0] f7);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic rv32i_pkg::rv32i_word i_insn(input logic [6:0] op, input logic [4:0] rd,
		input logic [2:0] f3, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rv32i_pkg::rv32i_word u_insn(input logic [6:0] op, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic rv32i_pkg::rv32i_word b_insn(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic rv32i_pkg::rv32i_word j_insn(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic load_program();
		// unused words hold lui x31 with their own index
		for (int i = 0; i < ROM_WORDS; i++)
			rom[i[5:0]] = u_insn(rv32i_pkg::op_lui, 5'd31, 20'(i));
		// alu ops with dependent neighbours
		rom[0]  = i_insn(rv32i_pkg::op_imm, 5'd1, 3'b000, 5'd0, 12'd5);
		rom[1]  = i_insn(rv32i_pkg::op_imm, 5'd2, 3'b000, 5'd1, 12'd7);
		rom[2]  = r_insn(5'd3, 3'b000, 5'd1, 5'd2, 7'h00);
		rom[3]  = r_insn(5'd4, 3'b000, 5'd3, 5'd1, 7'h20);
		rom[4]  = u_insn(rv32i_pkg::op_lui, 5'd5, 20'h12345);
		rom[5]  = u_insn(rv32i_pkg::op_auipc, 5'd6, 20'h00001);
		rom[6]  = i_insn(rv32i_pkg::op_imm, 5'd7, 3'b100, 5'd5, 12'hfff);
		rom[7]  = i_insn(rv32i_pkg::op_imm, 5'd8, 3'b001, 5'd2, 12'h004);
		rom[8]  = i_insn(rv32i_pkg::op_imm, 5'd9, 3'b101, 5'd7, 12'h408);
		rom[9]  = i_insn(rv32i_pkg::op_imm, 5'd10, 3'b101, 5'd7, 12'h01c);
		rom[10] = r_insn(5'd11, 3'b010, 5'd7, 5'd1, 7'h00);
		rom[11] = r_insn(5'd12, 3'b011, 5'd7, 5'd1, 7'h00);
		rom[12] = r_insn(5'd13, 3'b110, 5'd8, 5'd10, 7'h00);
		rom[13] = r_insn(5'd14, 3'b111, 5'd9, 5'd5, 7'h00);
		// beq taken, then bne not taken
		rom[14] = b_insn(3'b000, 5'd2, 5'd4, 13'd12);
		rom[15] = i_insn(rv32i_pkg::op_imm, 5'd15, 3'b000, 5'd0, 12'd1);
		rom[16] = i_insn(rv32i_pkg::op_imm, 5'd16, 3'b000, 5'd0, 12'd2);
		rom[17] = b_insn(3'b001, 5'd1, 5'd1, 13'd8);
		rom[18] = i_insn(rv32i_pkg::op_imm, 5'd17, 3'b000, 5'd0, 12'd33);
		rom[19] = i_insn(rv32i_pkg::op_imm, 5'd18, 3'b011, 5'd17, 12'd40);
		// jal, then jalr to an odd target
		rom[20] = j_insn(5'd19, 21'd12);
		rom[21] = i_insn(rv32i_pkg::op_imm, 5'd20, 3'b000, 5'd0, 12'd3);
		rom[22] = i_insn(rv32i_pkg::op_imm, 5'd21, 3'b000, 5'd0, 12'd4);
		rom[23] = i_insn(rv32i_pkg::op_imm, 5'd22, 3'b000, 5'd19, 12'h025);
		rom[24] = i_insn(rv32i_pkg::op_jalr, 5'd23, 3'b000, 5'd22, 12'd12);
		rom[25] = i_insn(rv32i_pkg::op_imm, 5'd24, 3'b000, 5'd0, 12'd5);
		rom[26] = i_insn(rv32i_pkg::op_imm, 5'd25, 3'b000, 5'd0, 12'd6);
		rom[33] = r_insn(5'd26, 3'b000, 5'd23, 5'd19, 7'h00);
		rom[34] = b_insn(3'b100, 5'd7, 5'd1, 13'd12);
		rom[35] = i_insn(rv32i_pkg::op_imm, 5'd27, 3'b000, 5'd0, 12'd7);
		rom[36] = i_insn(rv32i_pkg::op_imm, 5'd28, 3'b000, 5'd0, 12'd8);
		rom[37] = b_insn(3'b111, 5'd7, 5'd1, 13'd12);
		rom[38] = i_insn(rv32i_pkg::op_imm, 5'd29, 3'b000, 5'd0, 12'd9);
		rom[39] = i_insn(rv32i_pkg::op_imm, 5'd31, 3'b000, 5'd0, 12'd10);
		rom[40] = r_insn(5'd30, 3'b101, 5'd7, 5'd10, 7'h20);
		// parks here, rd is x0
		rom[41] = j_insn(5'd0, 21'd0);
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic wait_for_commit();
		do
			@(posedge clk);
		while (!wb_valid);
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// inputs change on the falling edge only
	initial begin
		void'($urandom(15790));
		load_program();
		rst           = 1'b1;
		load_pipeline = 1'b0;
		inst          = 32'h0000_0000;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		forever begin
			inst          = rom[inst_addr[7:2]];
			load_pipeline = (rows_done < HALF_ROWS) ? 1'b1 :
				(($urandom % 32'd4) != 32'd0);
			@(negedge clk);
		end
	end

	initial begin
		@(negedge rst);
		@(posedge clk);
		assert (inst_addr == rv32i_pkg::reset_pc)
			else abort_run($sformatf("mismatch at %0t: inst_addr expected 0x%08h, got 0x%08h",
				$time, rv32i_pkg::reset_pc, inst_addr));
		assert (!wb_valid)
			else abort_run($sformatf("mismatch at %0t: wb_valid expected 0, got %0b",
				$time, wb_valid));
		for (int r = 0; r < NUM_ROWS; r++) begin
			wait_for_commit();
			assert (wb_dest == expected[r[4:0]].dest)
				else abort_run($sformatf("mismatch at %0t: wb_dest expected %0d, got %0d",
					$time, expected[r[4:0]].dest, wb_dest));
			assert (wb_data == expected[r[4:0]].data)
				else abort_run($sformatf("mismatch at %0t: wb_data expected 0x%08h, got 0x%08h",
					$time, expected[r[4:0]].data, wb_data));
			rows_done = r + 1;
		end
		repeat (TAIL_CYCLES) begin
			@(posedge clk);
			assert (!wb_valid)
				else abort_run($sformatf("unexpected commit to x%0d after the last row at %0t",
					wb_dest, $time));
		end
		$display("RESULT: PASS");
		$finish;
	end

	initial begin
		@(negedge rst);
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count >= TIMEOUT_CYCLES) begin
				if (rows_done < NUM_ROWS)
					abort_run("not all expected commits seen before timeout");
				else
					abort_run("run did not finish before timeout");
			end
		end
	end

endmodule

`default_nettype wire

/* datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       load_pipeline,
	input  wire rv32i_pkg::rv32i_word ifid_pc,
	input  wire rv32i_pkg::rv32i_word ifid_inst,
	input  wire                       ifid_flush,
	output logic                      redirect,
	output rv32i_pkg::rv32i_word      redirect_target,
	output logic                      wb_valid,
	output rv32i_pkg::rv32i_reg       wb_dest,
	output rv32i_pkg::rv32i_word      wb_data
);

	// result of a stage, as it will be written back
	function automatic rv32i_pkg::rv32i_word result_sel(
		input rv32i_pkg::regfilemux_sel_t sel,
		input rv32i_pkg::rv32i_word       alu_res,
		input logic                       cmp_res,
		input rv32i_pkg::rv32i_word       u_imm,
		input rv32i_pkg::rv32i_word       pc
	);
		case (sel)
			rv32i_pkg::rf_br_en:    return {31'b0, cmp_res};
			rv32i_pkg::rf_u_imm:    return u_imm;
			rv32i_pkg::rf_pc_plus4: return pc + 32'd4;
			default:                return alu_res;
		endcase
	endfunction

	rv32i_pkg::control_word_t id_cw;
	rv32i_pkg::control_word_t idex_cw;
	rv32i_pkg::control_word_t exmem_cw;
	rv32i_pkg::control_word_t memwb_cw;
	rv32i_pkg::rv32i_word     reg_a;
	rv32i_pkg::rv32i_word     reg_b;
	rv32i_pkg::rv32i_word     rs1_in;
	rv32i_pkg::rv32i_word     rs2_in;
	logic                     fwd_id_rs1;
	logic                     fwd_id_rs2;
	logic [1:0]               fwd_rs1;
	logic [1:0]               fwd_rs2;
	rv32i_pkg::rv32i_word     idex_pc;
	rv32i_pkg::rv32i_word     idex_rs1;
	rv32i_pkg::rv32i_word     idex_rs2;
	rv32i_pkg::rv32i_word     ex_rs1;
	rv32i_pkg::rv32i_word     ex_rs2;
	rv32i_pkg::rv32i_word     alu_a;
	rv32i_pkg::rv32i_word     alu_b;
	rv32i_pkg::rv32i_word     cmp_b;
	rv32i_pkg::rv32i_word     alu_out;
	logic                     br_en;
	rv32i_pkg::rv32i_word     exmem_pc;
	rv32i_pkg::rv32i_word     exmem_alu;
	logic                     exmem_br;
	rv32i_pkg::rv32i_word     mem_fwd;
	rv32i_pkg::rv32i_word     memwb_pc;
	rv32i_pkg::rv32i_word     memwb_alu;
	logic                     memwb_br;

	// decode, squashed when execute redirects
	control u_control (
		.data  (ifid_inst),
		.flush (ifid_flush || redirect),
		.cw    (id_cw)
	);

	regfile u_regfile (
		.clk   (clk),
		.rst   (rst),
		.load  (wb_valid),
		.in    (wb_data),
		.src_a (id_cw.src1),
		.src_b (id_cw.src2),
		.dest  (memwb_cw.dest),
		.reg_a (reg_a),
		.reg_b (reg_b)
	);

	hazard_unit u_hazard (
		.idex_cw    (idex_cw),
		.exmem_cw   (exmem_cw),
		.memwb_cw   (memwb_cw),
		.id_cw      (id_cw),
		.fwd_rs1    (fwd_rs1),
		.fwd_rs2    (fwd_rs2),
		.fwd_id_rs1 (fwd_id_rs1),
		.fwd_id_rs2 (fwd_id_rs2)
	);

	assign rs1_in = fwd_id_rs1 ? wb_data : reg_a;
	assign rs2_in = fwd_id_rs2 ? wb_data : reg_b;

	// execute operands
	assign ex_rs1 = (fwd_rs1 == rv32i_pkg::fwd_mem) ? mem_fwd :
		(fwd_rs1 == rv32i_pkg::fwd_wb) ? wb_data : idex_rs1;
	assign ex_rs2 = (fwd_rs2 == rv32i_pkg::fwd_mem) ? mem_fwd :
		(fwd_rs2 == rv32i_pkg::fwd_wb) ? wb_data : idex_rs2;
	assign alu_a  = (idex_cw.alumux1_sel == rv32i_pkg::mux1_pc) ? idex_pc : ex_rs1;
	assign cmp_b  = (idex_cw.cmpmux_sel == rv32i_pkg::cmp_i_imm) ? idex_cw.i_imm : ex_rs2;

	always_comb begin
		case (idex_cw.alumux2_sel)
			rv32i_pkg::mux2_u_imm: alu_b = idex_cw.u_imm;
			rv32i_pkg::mux2_b_imm: alu_b = idex_cw.b_imm;
			rv32i_pkg::mux2_s_imm: alu_b = idex_cw.s_imm;
			rv32i_pkg::mux2_j_imm: alu_b = idex_cw.j_imm;
			rv32i_pkg::mux2_rs2:   alu_b = ex_rs2;
			default:               alu_b = idex_cw.i_imm;
		endcase
	end

	alu u_alu (
		.aluop (idex_cw.aluop),
		.cmpop (idex_cw.cmpop),
		.a     (alu_a),
		.b     (alu_b),
		.cmp_a (ex_rs1),
		.cmp_b (cmp_b),
		.f     (alu_out),
		.br_en (br_en)
	);

	assign redirect = !idex_cw.flush && ((idex_cw.opcode == rv32i_pkg::op_br && br_en) ||
		idex_cw.opcode == rv32i_pkg::op_jal || idex_cw.opcode == rv32i_pkg::op_jalr);
	assign redirect_target = (idex_cw.opcode == rv32i_pkg::op_jalr) ?
		{alu_out[31:1], 1'b0} : alu_out;

	assign mem_fwd  = result_sel(exmem_cw.regfilemux_sel, exmem_alu, exmem_br,
		exmem_cw.u_imm, exmem_pc);
	assign wb_data  = result_sel(memwb_cw.regfilemux_sel, memwb_alu, memwb_br,
		memwb_cw.u_imm, memwb_pc);
	assign wb_dest  = memwb_cw.dest;
	// one commit per advancing edge
	assign wb_valid = load_pipeline && memwb_cw.load_regfile && memwb_cw.rd_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			idex_cw  <= rv32i_pkg::cw_bubble;
			exmem_cw <= rv32i_pkg::cw_bubble;
			memwb_cw <= rv32i_pkg::cw_bubble;
		end else if (load_pipeline) begin
			idex_cw  <= id_cw;
			exmem_cw <= idex_cw;
			memwb_cw <= exmem_cw;
		end
	end

	always_ff @(posedge clk) begin
		if (load_pipeline) begin
			idex_pc   <= ifid_pc;
			idex_rs1  <= rs1_in;
			idex_rs2  <= rs2_in;
			exmem_pc  <= idex_pc;
			exmem_alu <= alu_out;
			exmem_br  <= br_en;
			memwb_pc  <= exmem_pc;
			memwb_alu <= exmem_alu;
			memwb_br  <= exmem_br;
		end
	end

endmodule

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       load_pipeline,
	input  wire rv32i_pkg::rv32i_word inst,
	input  wire                       redirect,
	input  wire rv32i_pkg::rv32i_word redirect_target,
	output rv32i_pkg::rv32i_word      inst_addr,
	output rv32i_pkg::rv32i_word      ifid_pc,
	output rv32i_pkg::rv32i_word      ifid_inst,
	output logic                      ifid_flush
);

	rv32i_pkg::rv32i_word pc;
	rv32i_pkg::rv32i_word pc_next;

	assign inst_addr = pc;
	// static not-taken, execute overrides
	assign pc_next   = redirect ? redirect_target : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc         <= rv32i_pkg::reset_pc;
			ifid_flush <= 1'b1;
		end else if (load_pipeline) begin
			pc         <= pc_next;
			ifid_flush <= redirect;
		end
	end

	always_ff @(posedge clk) begin
		if (load_pipeline) begin
			ifid_pc   <= pc;
			ifid_inst <= inst;
		end
	end

endmodule

`default_nettype wire

/* hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	input  wire rv32i_pkg::control_word_t idex_cw,
	input  wire rv32i_pkg::control_word_t exmem_cw,
	input  wire rv32i_pkg::control_word_t memwb_cw,
	input  wire rv32i_pkg::control_word_t id_cw,
	output logic [1:0]                    fwd_rs1,
	output logic [1:0]                    fwd_rs2,
	output logic                          fwd_id_rs1,
	output logic                          fwd_id_rs2
);

	function automatic logic hit(
		input logic                     src_valid,
		input rv32i_pkg::rv32i_reg      src,
		input rv32i_pkg::control_word_t older
	);
		return src_valid && older.load_regfile && older.rd_valid && (src == older.dest);
	endfunction

	// memory stage is younger, so it wins
	function automatic logic [1:0] ex_sel(
		input logic                rs_valid,
		input rv32i_pkg::rv32i_reg rs
	);
		if (hit(rs_valid, rs, exmem_cw))
			return rv32i_pkg::fwd_mem;
		if (hit(rs_valid, rs, memwb_cw))
			return rv32i_pkg::fwd_wb;
		return rv32i_pkg::fwd_none;
	endfunction

	assign fwd_rs1    = ex_sel(idex_cw.rs1_valid, idex_cw.src1);
	assign fwd_rs2    = ex_sel(idex_cw.rs2_valid, idex_cw.src2);
	assign fwd_id_rs1 = hit(id_cw.rs1_valid, id_cw.src1, memwb_cw);
	assign fwd_id_rs2 = hit(id_cw.rs2_valid, id_cw.src2, memwb_cw);

endmodule

`default_nettype wire

/* regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       load,
	input  wire rv32i_pkg::rv32i_word in,
	input  wire rv32i_pkg::rv32i_reg  src_a,
	input  wire rv32i_pkg::rv32i_reg  src_b,
	input  wire rv32i_pkg::rv32i_reg  dest,
	output rv32i_pkg::rv32i_word      reg_a,
	output rv32i_pkg::rv32i_word      reg_b
);

	rv32i_pkg::rv32i_word data [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				data[i] <= '0;
		end else if (load && dest != 5'd0) begin
			data[dest] <= in;
		end
	end

	// x0 reads as zero
	assign reg_a = (src_a == 5'd0) ? '0 : data[src_a];
	assign reg_b = (src_b == 5'd0) ? '0 : data[src_b];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module cpu_tb -f sim.f -o Vcpu_tb
./obj_dir/Vcpu_tb 2>&1 | tee sim.log
if grep -q "RESULT: FAIL" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
	echo "simulation ended without a pass result"
	exit 1
fi
echo "simulation passed"

/* rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

	typedef logic [31:0] rv32i_word;
	typedef logic [4:0] rv32i_reg;

	localparam rv32i_word reset_pc = 32'h0000_0000;

	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv32i_opcode;

	// low six codes line up with funct3 of the matching ops
	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_sll = 3'b001,
		alu_sra = 3'b010,
		alu_sub = 3'b011,
		alu_xor = 3'b100,
		alu_srl = 3'b101,
		alu_or  = 3'b110,
		alu_and = 3'b111
	} alu_ops;

	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3_t;

	typedef enum logic {
		mux1_rs1 = 1'b0,
		mux1_pc  = 1'b1
	} alumux1_sel_t;

	typedef enum logic [2:0] {
		mux2_i_imm = 3'd0,
		mux2_u_imm = 3'd1,
		mux2_b_imm = 3'd2,
		mux2_s_imm = 3'd3,
		mux2_j_imm = 3'd4,
		mux2_rs2   = 3'd5
	} alumux2_sel_t;

	typedef enum logic {
		cmp_rs2   = 1'b0,
		cmp_i_imm = 1'b1
	} cmpmux_sel_t;

	typedef enum logic [1:0] {
		rf_alu_out  = 2'd0,
		rf_br_en    = 2'd1,
		rf_u_imm    = 2'd2,
		rf_pc_plus4 = 2'd3
	} regfilemux_sel_t;

	typedef struct packed {
		rv32i_opcode     opcode;
		alu_ops          aluop;
		branch_funct3_t  cmpop;
		alumux1_sel_t    alumux1_sel;
		alumux2_sel_t    alumux2_sel;
		cmpmux_sel_t     cmpmux_sel;
		regfilemux_sel_t regfilemux_sel;
		rv32i_reg        src1;
		rv32i_reg        src2;
		rv32i_reg        dest;
		logic            rs1_valid;
		logic            rs2_valid;
		logic            rd_valid;
		logic            load_regfile;
		rv32i_word       i_imm;
		rv32i_word       s_imm;
		rv32i_word       b_imm;
		rv32i_word       u_imm;
		rv32i_word       j_imm;
		// lsb, so a bubble is all zeros but this bit
		logic            flush;
	} control_word_t;

	localparam control_word_t cw_bubble =
		control_word_t'({{($bits(control_word_t) - 1){1'b0}}, 1'b1});

	// forwarding selects into execute
	localparam logic [1:0] fwd_none = 2'd0;
	localparam logic [1:0] fwd_mem  = 2'd1;
	localparam logic [1:0] fwd_wb   = 2'd2;

endpackage

`default_nettype wire

/* sim.f */
rv32i_pkg.sv
control.sv
regfile.sv
alu.sv
hazard_unit.sv
fetch_unit.sv
datapath.sv
cpu.sv
cpu_sva.sv
cpu_tb.sv
